/* sb_pkg.sv */
package sb_pkg;

    typedef logic [4:0] reg_idx_t;
    typedef logic [2:0] fu_id_t;

    localparam fu_id_t FU_NONE = 3'd0;
    localparam fu_id_t FU_ALU  = 3'd1;
    localparam fu_id_t FU_MEM  = 3'd2;
    localparam fu_id_t FU_MUL  = 3'd3;
    localparam fu_id_t FU_DIV  = 3'd4;

    localparam int NUM_FU = 4;    // entry index is unit id minus 1

    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    typedef struct packed {
        logic       use_imm;    // rs2 replaced by immediate
        logic [3:0] alu_op;
    } alu_view_t;

    typedef struct packed {
        logic       pad;
        logic [2:0] bhw;        // same coding as load/store funct3
        logic       we;
    } mem_view_t;

    typedef struct packed {
        logic [2:0] pad;
        logic [1:0] md_op;
    } muldiv_view_t;

    typedef union packed {
        alu_view_t    alu;
        mem_view_t    mem;
        muldiv_view_t muldiv;
    } fu_op_u;

    // alu ops, register form, use_imm is set by decode for the I-type forms
    localparam logic [4:0] ALU_ADD  = 5'd0;
    localparam logic [4:0] ALU_SUB  = 5'd1;
    localparam logic [4:0] ALU_SLL  = 5'd2;
    localparam logic [4:0] ALU_SLT  = 5'd3;
    localparam logic [4:0] ALU_SLTU = 5'd4;
    localparam logic [4:0] ALU_XOR  = 5'd5;
    localparam logic [4:0] ALU_SRL  = 5'd6;
    localparam logic [4:0] ALU_SRA  = 5'd7;
    localparam logic [4:0] ALU_OR   = 5'd8;
    localparam logic [4:0] ALU_AND  = 5'd9;

    localparam logic [4:0] MEM_LB  = 5'b0_000_0;
    localparam logic [4:0] MEM_LH  = 5'b0_001_0;
    localparam logic [4:0] MEM_LW  = 5'b0_010_0;
    localparam logic [4:0] MEM_LBU = 5'b0_100_0;
    localparam logic [4:0] MEM_LHU = 5'b0_101_0;
    localparam logic [4:0] MEM_SB  = 5'b0_000_1;
    localparam logic [4:0] MEM_SH  = 5'b0_001_1;
    localparam logic [4:0] MEM_SW  = 5'b0_010_1;

    localparam logic [4:0] MUL_MUL    = 5'd0;
    localparam logic [4:0] MUL_MULH   = 5'd1;
    localparam logic [4:0] MUL_MULHSU = 5'd2;
    localparam logic [4:0] MUL_MULHU  = 5'd3;
    localparam logic [4:0] DIV_DIV    = 5'd0;
    localparam logic [4:0] DIV_DIVU   = 5'd1;
    localparam logic [4:0] DIV_REM    = 5'd2;
    localparam logic [4:0] DIV_REMU   = 5'd3;

    typedef struct packed {
        fu_id_t   fu;
        fu_op_u   op;
        reg_idx_t dst;      // 0 when nothing is written
        reg_idx_t src1;
        reg_idx_t src2;
    } issue_req_t;

    typedef struct packed {
        logic     busy;
        fu_op_u   op;
        reg_idx_t dst;
        reg_idx_t src1;
        reg_idx_t src2;
        fu_id_t   fu1;      // producer of src1 still pending
        fu_id_t   fu2;
        logic     rdy1;
        logic     rdy2;
        logic     done;
    } fu_entry_t;

    typedef struct packed {
        logic     valid;
        fu_id_t   fu;
        fu_op_u   op;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } read_req_t;

    typedef struct packed {
        logic     valid;
        fu_id_t   fu;
        reg_idx_t rd;
    } wb_req_t;

endpackage

/* inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]        inst,
    output sb_pkg::issue_req_t req
);
    import sb_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_imm;     // I-type alu form
    logic       alt;        // funct7 0x20, sub and sra
    logic       f7_zero;
    logic [4:0] alu_sel;
    logic       alu_ok;
    fu_id_t     fu;
    fu_op_u     op;
    logic       has_rd;
    logic       has_rs1;
    logic       has_rs2;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign is_imm  = (opcode == OPC_I);
    assign alt     = (funct7 == 7'h20);
    assign f7_zero = (funct7 == 7'h00);

    // shared alu table, funct7 only matters for R-type and the shifts
    always_comb begin
        alu_sel = ALU_ADD;
        alu_ok  = is_imm || f7_zero;
        case (funct3)
            3'h0: begin
                alu_sel = (alt && !is_imm) ? ALU_SUB : ALU_ADD;
                alu_ok  = is_imm || f7_zero || alt;
            end
            3'h1: begin
                alu_sel = ALU_SLL;
                alu_ok  = f7_zero;
            end
            3'h2: alu_sel = ALU_SLT;
            3'h3: alu_sel = ALU_SLTU;
            3'h4: alu_sel = ALU_XOR;
            3'h5: begin
                alu_sel = alt ? ALU_SRA : ALU_SRL;
                alu_ok  = f7_zero || alt;
            end
            3'h6: alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    end

    always_comb begin
        fu      = FU_NONE;
        op      = '0;
        has_rd  = 1'b0;
        has_rs1 = 1'b0;
        has_rs2 = 1'b0;
        case (opcode)
            OPC_R: begin
                has_rd  = 1'b1;
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;
                if (funct7 == 7'h01) begin
                    fu = funct3[2] ? FU_DIV : FU_MUL;
                    case (funct3)
                        3'h0: op = MUL_MUL;
                        3'h1: op = MUL_MULH;
                        3'h2: op = MUL_MULHSU;
                        3'h3: op = MUL_MULHU;
                        3'h4: op = DIV_DIV;
                        3'h5: op = DIV_DIVU;
                        3'h6: op = DIV_REM;
                        default: op = DIV_REMU;
                    endcase
                end else if (alu_ok) begin
                    fu = FU_ALU;
                    op = alu_sel;
                end
            end
            OPC_I: begin
                has_rd  = 1'b1;
                has_rs1 = 1'b1;
                if (alu_ok) begin
                    fu             = FU_ALU;
                    op             = alu_sel;
                    op.alu.use_imm = 1'b1;
                end
            end
            OPC_LOAD: begin
                has_rd  = 1'b1;
                has_rs1 = 1'b1;
                fu      = FU_MEM;
                case (funct3)
                    3'h0: op = MEM_LB;
                    3'h1: op = MEM_LH;
                    3'h2: op = MEM_LW;
                    3'h4: op = MEM_LBU;
                    3'h5: op = MEM_LHU;
                    default: fu = FU_NONE;
                endcase
            end
            OPC_STORE: begin
                has_rs1 = 1'b1;     // base
                has_rs2 = 1'b1;     // store data
                fu      = FU_MEM;
                case (funct3)
                    3'h0: op = MEM_SB;
                    3'h1: op = MEM_SH;
                    3'h2: op = MEM_SW;
                    default: fu = FU_NONE;
                endcase
            end
            default: fu = FU_NONE;  // unsupported, never issues
        endcase
    end

    assign req = '{fu:   fu,
                   op:   op,
                   dst:  has_rd  ? inst[11:7]  : 5'd0,
                   src1: has_rs1 ? inst[19:15] : 5'd0,
                   src2: has_rs2 ? inst[24:20] : 5'd0};

endmodule

/* fu_status_table.sv */
`timescale 1ns/1ps

module fu_status_table (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   inst_valid,
    input  sb_pkg::issue_req_t                     req,
    input  logic [sb_pkg::NUM_FU-1:0]              read_grant,
    input  logic [sb_pkg::NUM_FU-1:0]              wb_grant,
    input  logic [sb_pkg::NUM_FU-1:0]              fu_done,
    output logic                                   issue_ok,
    output sb_pkg::fu_entry_t [sb_pkg::NUM_FU-1:0] entries
);
    import sb_pkg::*;

    fu_entry_t [NUM_FU-1:0] ent_q;
    fu_id_t                 rrs [32];   // unit that will write each register
    logic [1:0]             slot;
    logic                   issue_fire;
    fu_id_t                 wb_id;
    reg_idx_t               wb_dst;
    fu_id_t                 fu1_new;
    fu_id_t                 fu2_new;
    fu_entry_t              new_entry;

    assign entries = ent_q;
    assign slot    = 2'(req.fu - 3'd1);

    // structural hazard and WAW
    assign issue_ok = (req.fu != FU_NONE) && !ent_q[slot].busy &&
                      ((rrs[req.dst] == FU_NONE) || (req.dst == 5'd0));

    assign issue_fire = inst_valid && issue_ok;

    // unit and destination of this cycle's write-back
    always_comb begin
        wb_id  = FU_NONE;
        wb_dst = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (wb_grant[i]) begin
                wb_id  = fu_id_t'(i + 1);
                wb_dst = ent_q[i].dst;
            end
        end
    end

    // a producer writing back this cycle no longer counts as pending
    assign fu1_new = (rrs[req.src1] == wb_id) ? FU_NONE : rrs[req.src1];
    assign fu2_new = (rrs[req.src2] == wb_id) ? FU_NONE : rrs[req.src2];

    assign new_entry = '{busy: 1'b1,
                         op:   req.op,
                         dst:  req.dst,
                         src1: req.src1,
                         src2: req.src2,
                         fu1:  fu1_new,
                         fu2:  fu2_new,
                         rdy1: (fu1_new == FU_NONE),
                         rdy2: (fu2_new == FU_NONE),
                         done: 1'b0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_q <= '0;
        end else begin
            for (int i = 0; i < NUM_FU; i++) begin
                if (issue_fire && slot == 2'(i)) begin
                    ent_q[i] <= new_entry;
                end else if (wb_grant[i]) begin
                    ent_q[i] <= '0;     // unit free again
                end else begin
                    if (read_grant[i]) begin
                        ent_q[i].rdy1 <= 1'b0;  // operands taken
                        ent_q[i].rdy2 <= 1'b0;
                    end
                    // RAW wake-up, producer field cleared so it fires once
                    if (wb_id != FU_NONE && ent_q[i].fu1 == wb_id) begin
                        ent_q[i].fu1  <= FU_NONE;
                        ent_q[i].rdy1 <= 1'b1;
                    end
                    if (wb_id != FU_NONE && ent_q[i].fu2 == wb_id) begin
                        ent_q[i].fu2  <= FU_NONE;
                        ent_q[i].rdy2 <= 1'b1;
                    end
                    if (fu_done[i] && ent_q[i].busy) begin
                        ent_q[i].done <= 1'b1;  // strobe for an idle unit dropped
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                rrs[r] <= FU_NONE;
            end
        end else begin
            if (wb_id != FU_NONE) begin
                rrs[wb_dst] <= FU_NONE;
            end
            if (issue_fire && req.dst != 5'd0) begin
                rrs[req.dst] <= req.fu;     // x0 never pending
            end
        end
    end

endmodule

/* read_dispatch.sv */
`timescale 1ns/1ps

module read_dispatch (
    input  sb_pkg::fu_entry_t [sb_pkg::NUM_FU-1:0] entries,
    output logic [sb_pkg::NUM_FU-1:0]              read_grant,
    output sb_pkg::read_req_t                      read
);
    import sb_pkg::*;

    logic [NUM_FU-1:0] ready;

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            ready[i] = entries[i].busy && entries[i].rdy1 && entries[i].rdy2;
        end
    end

    // fixed priority alu > mem > mul > div
    // walk from lowest priority so the highest ready unit is written last
    always_comb begin
        read_grant = '0;
        read       = '0;
        for (int i = NUM_FU - 1; i >= 0; i--) begin
            if (ready[i]) begin
                read_grant    = '0;
                read_grant[i] = 1'b1;
                read.valid    = 1'b1;
                read.fu       = fu_id_t'(i + 1);
                read.op       = entries[i].op;
                read.rs1      = entries[i].src1;
                read.rs2      = entries[i].src2;
            end
        end
    end

endmodule

/* writeback_select.sv */
`timescale 1ns/1ps

module writeback_select (
    input  sb_pkg::fu_entry_t [sb_pkg::NUM_FU-1:0] entries,
    output logic [sb_pkg::NUM_FU-1:0]              wb_grant,
    output sb_pkg::wb_req_t                        wb
);
    import sb_pkg::*;

    logic [NUM_FU-1:0] war_ok;

    // WAR check, no other unit may still have to read this destination
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            war_ok[i] = 1'b1;
            for (int j = 0; j < NUM_FU; j++) begin
                if (j != i && entries[j].busy && entries[i].dst != 5'd0) begin
                    if (entries[j].rdy1 && entries[j].src1 == entries[i].dst) begin
                        war_ok[i] = 1'b0;
                    end
                    if (entries[j].rdy2 && entries[j].src2 == entries[i].dst) begin
                        war_ok[i] = 1'b0;
                    end
                end
            end
        end
    end

    // same priority order as read, alu wins
    always_comb begin
        wb_grant = '0;
        wb       = '0;
        for (int i = NUM_FU - 1; i >= 0; i--) begin
            if (entries[i].busy && entries[i].done && war_ok[i]) begin
                wb_grant    = '0;
                wb_grant[i] = 1'b1;
                wb.valid    = 1'b1;
                wb.fu       = fu_id_t'(i + 1);
                wb.rd       = entries[i].dst;
            end
        end
    end

endmodule

/* sb_top.sv */
`timescale 1ns/1ps

module sb_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid,
    input  logic [31:0]               inst,
    input  logic [sb_pkg::NUM_FU-1:0] fu_done,     // bit = unit id minus 1
    output logic                      issue_ok,
    output sb_pkg::read_req_t         read,
    output sb_pkg::wb_req_t           wb
);
    import sb_pkg::*;

    issue_req_t             req;
    fu_entry_t [NUM_FU-1:0] entries;
    logic [NUM_FU-1:0]      read_grant;
    logic [NUM_FU-1:0]      wb_grant;

    inst_decoder decoder_i (
        .inst (inst),
        .req  (req)
    );

    fu_status_table table_i (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .req        (req),
        .read_grant (read_grant),
        .wb_grant   (wb_grant),
        .fu_done    (fu_done),
        .issue_ok   (issue_ok),
        .entries    (entries)
    );

    read_dispatch read_i (
        .entries    (entries),
        .read_grant (read_grant),
        .read       (read)
    );

    writeback_select wb_i (
        .entries  (entries),
        .wb_grant (wb_grant),
        .wb       (wb)
    );

endmodule

/* tb_sb_cases.svh */
add_step("idle",         0, 32'h0, 4'h0, 0, NO_READ, NO_WB);
add_step("add_issue",    1, r_word(7'h00, 3'h0, 3, 1, 2), 4'h0, 1, NO_READ, NO_WB);
add_step("add_read",     0, 32'h0, 4'h0, 0, read_of(FU_ALU, ALU_ADD, 1, 2), NO_WB);
// second alu op held off while the first is in flight
add_step("alu_busy",     1, r_word(7'h00, 3'h0, 5, 6, 7), 4'h1, 0, NO_READ, NO_WB);
add_step("add_wb",       1, r_word(7'h00, 3'h0, 5, 6, 7), 4'h0, 0, NO_READ, wb_of(FU_ALU, 3));
add_step("alu_free",     1, r_word(7'h00, 3'h0, 5, 6, 7), 4'h0, 1, NO_READ, NO_WB);
add_step("mul_waw",      1, r_word(7'h01, 3'h0, 5, 8, 9), 4'h1, 0,
         read_of(FU_ALU, ALU_ADD, 6, 7), NO_WB);   // x5 still pending
add_step("waw_wb",       1, r_word(7'h01, 3'h0, 5, 8, 9), 4'h0, 0, NO_READ, wb_of(FU_ALU, 5));
add_step("mul_issue",    1, r_word(7'h01, 3'h0, 5, 8, 9), 4'h0, 1, NO_READ, NO_WB);
add_step("mul_read",     0, 32'h0, 4'h4, 0, read_of(FU_MUL, MUL_MUL, 8, 9), NO_WB);
add_step("mul_wb",       0, 32'h0, 4'h0, 0, NO_READ, wb_of(FU_MUL, 5));
// sub waits on the div result in x10
add_step("div_issue",    1, r_word(7'h01, 3'h4, 10, 11, 12), 4'h0, 1, NO_READ, NO_WB);
add_step("sub_issue",    1, r_word(7'h20, 3'h0, 13, 10, 14), 4'h0, 1,
         read_of(FU_DIV, DIV_DIV, 11, 12), NO_WB);
add_step("sub_wait",     0, 32'h0, 4'h8, 0, NO_READ, NO_WB);
add_step("div_wb",       0, 32'h0, 4'h0, 0, NO_READ, wb_of(FU_DIV, 10));
add_step("sub_read",     0, 32'h0, 4'h1, 0, read_of(FU_ALU, ALU_SUB, 10, 14), NO_WB);
add_step("sub_wb",       0, 32'h0, 4'h0, 0, NO_READ, wb_of(FU_ALU, 13));
// alu and mem both wake on the same mul write-back
add_step("mul_issue2",   1, r_word(7'h01, 3'h0, 20, 1, 2), 4'h0, 1, NO_READ, NO_WB);
add_step("add_dep",      1, r_word(7'h00, 3'h0, 21, 20, 0), 4'h0, 1,
         read_of(FU_MUL, MUL_MUL, 1, 2), NO_WB);
add_step("lw_dep",       1, load_word(3'h2, 22, 20), 4'h4, 1, NO_READ, NO_WB);
add_step("mul_wb2",      0, 32'h0, 4'h0, 0, NO_READ, wb_of(FU_MUL, 20));
add_step("prio_alu",     0, 32'h0, 4'h0, 0, read_of(FU_ALU, ALU_ADD, 20, 0), NO_WB);
add_step("prio_mem",     0, 32'h0, 4'h3, 0,
         read_of(FU_MEM, mem_op(3'h2, 1'b0), 20, 0), NO_WB);   // word load with we low
add_step("wb_alu",       0, 32'h0, 4'h0, 0, NO_READ, wb_of(FU_ALU, 21));
add_step("wb_mem",       0, 32'h0, 4'h0, 0, NO_READ, wb_of(FU_MEM, 22));
// store data x6 must be read before the mul overwrites it
add_step("div_issue2",   1, r_word(7'h01, 3'h4, 7, 1, 2), 4'h0, 1, NO_READ, NO_WB);
add_step("sb_issue",     1, store_word(3'h0, 7, 6), 4'h0, 1,
         read_of(FU_DIV, DIV_DIV, 1, 2), NO_WB);
add_step("mul_war",      1, r_word(7'h01, 3'h0, 6, 3, 4), 4'h0, 1, NO_READ, NO_WB);
add_step("mul_war_read", 0, 32'h0, 4'h4, 0, read_of(FU_MUL, MUL_MUL, 3, 4), NO_WB);
add_step("war_hold",     0, 32'h0, 4'h8, 0, NO_READ, NO_WB);
add_step("div_wb2",      0, 32'h0, 4'h0, 0, NO_READ, wb_of(FU_DIV, 7));
add_step("sb_read",      0, 32'h0, 4'h0, 0,
         read_of(FU_MEM, mem_op(3'h0, 1'b1), 7, 6), NO_WB);    // byte store sets we
add_step("war_release",  0, 32'h0, 4'h2, 0, NO_READ, wb_of(FU_MUL, 6));
add_step("sb_wb",        0, 32'h0, 4'h0, 0, NO_READ, wb_of(FU_MEM, 0));
add_step("bad_opcode",   1, 32'h0000_007f, 4'h0, 0, NO_READ, NO_WB);
add_step("idle_end",     0, 32'h0, 4'h0, 0, NO_READ, NO_WB);

/* tb_sb_top.sv */
`timescale 1ns/1ps

module tb_sb_top;
    import sb_pkg::*;

    typedef struct {
        string             name;
        logic              valid;
        logic [31:0]       word;
        logic [NUM_FU-1:0] done;
        logic              ok;
        read_req_t         rd;
        wb_req_t           wb;
    } step_t;

    localparam read_req_t NO_READ = '0;
    localparam wb_req_t   NO_WB   = '0;

    logic              clk = 1'b0;
    logic              rst;
    logic              inst_valid;
    logic [31:0]       inst;
    logic [NUM_FU-1:0] fu_done;
    logic              issue_ok;
    read_req_t         read;
    wb_req_t           wb;

    step_t steps[$];
    int    step_errs;
    int    passed;
    int    failed;
    int    cycles;
    int    cycle_limit = 1000;   // replaced once the table is loaded

    sb_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .fu_done    (fu_done),
        .issue_ok   (issue_ok),
        .read       (read),
        .wb         (wb)
    );

    always #4 clk = ~clk;   // 8 ns period

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not end within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // RV32 encodings with the immediates left at zero
    function automatic logic [31:0] r_word(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                           reg_idx_t rs1, reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_R};
    endfunction

    function automatic logic [31:0] load_word(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1);
        return {12'h000, rs1, f3, rd, OPC_LOAD};
    endfunction

    function automatic logic [31:0] store_word(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2);
        return {7'h00, rs2, rs1, f3, 5'h00, OPC_STORE};
    endfunction

    // mem view of the op field with bhw in the load/store funct3 coding
    function automatic fu_op_u mem_op(logic [2:0] bhw, logic we);
        fu_op_u o;
        o         = '0;
        o.mem.bhw = bhw;
        o.mem.we  = we;
        return o;
    endfunction

    function automatic read_req_t read_of(fu_id_t fu, logic [4:0] op, reg_idx_t rs1,
                                          reg_idx_t rs2);
        read_req_t r;
        r.valid = 1'b1;
        r.fu    = fu;
        r.op    = op;
        r.rs1   = rs1;
        r.rs2   = rs2;
        return r;
    endfunction

    function automatic wb_req_t wb_of(fu_id_t fu, reg_idx_t rd);
        wb_req_t w;
        w.valid = 1'b1;
        w.fu    = fu;
        w.rd    = rd;
        return w;
    endfunction

    function automatic string show_read(read_req_t r);
        return $sformatf("v%b fu%0d op%h rs%0d,%0d", r.valid, r.fu, r.op, r.rs1, r.rs2);
    endfunction

    task automatic add_step(input string name, input logic valid, input logic [31:0] word,
                            input logic [NUM_FU-1:0] done, input logic ok,
                            input read_req_t exp_rd, input wb_req_t exp_wb);
        step_t s;
        s.name  = name;
        s.valid = valid;
        s.word  = word;
        s.done  = done;
        s.ok    = ok;
        s.rd    = exp_rd;
        s.wb    = exp_wb;
        steps.push_back(s);
    endtask

    task automatic load_steps();
        `include "tb_sb_cases.svh"
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: issue_ok expected %b actual %b", name, exp, act);
            step_errs++;
        end
    endtask

    task automatic verify_read(input string name, input read_req_t exp, input read_req_t act);
        if (act !== exp) begin
            $display("FAILED %s: read expected %s actual %s", name,
                     show_read(exp), show_read(act));
            step_errs++;
        end
    endtask

    task automatic compare_wb(input string name, input wb_req_t exp, input wb_req_t act);
        if (act !== exp) begin
            $display("FAILED %s: wb expected v%b fu%0d rd%0d actual v%b fu%0d rd%0d", name,
                     exp.valid, exp.fu, exp.rd, act.valid, act.fu, act.rd);
            step_errs++;
        end
    endtask

    initial begin
        step_t st;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        fu_done    = '0;
        load_steps();
        cycle_limit = steps.size() + 20;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int k = 0; k < steps.size(); k++) begin
            st         = steps[k];
            inst_valid = st.valid;
            inst       = st.word;
            fu_done    = st.done;
            #6;   // just before the next edge
            step_errs = 0;
            check_flag(st.name, st.ok, issue_ok);
            verify_read(st.name, st.rd, read);
            compare_wb(st.name, st.wb, wb);
            if (step_errs == 0) begin
                passed++;
                $display("step %0d %s: ok", k, st.name);
            end else begin
                failed++;
                $display("step %0d %s: %0d mismatches", k, st.name, step_errs);
            end
            @(posedge clk);
            #1;
        end
        $display("steps %0d, passed %0d, failed %0d", steps.size(), passed, failed);
        if (failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+.
sb_pkg.sv
inst_decoder.sv
fu_status_table.sv
read_dispatch.sv
writeback_select.sv
sb_top.sv
tb_sb_top.sv

/* Makefile */
TOP = tb_sb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --top-module $(TOP) -f src.f -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
